//--- rob_top.f
+incdir+.
rob_pkg.sv
rob_dualport_ram.sv
rob_slot_alloc.sv
rob_fill_track.sv
rob_drain.sv
rob_top.sv
rob_asserts.sv
rob_tb.sv

//--- rob_tb.sv
/*
 * Table-driven testbench for rob_top. Inputs change on the rising edge and
 * outputs are sampled on the falling edge. The first mismatch ends the run.
 */
`timescale 1ns/1ps
`include "rob_consts.svh"

module rob_tb;

    import rob_pkg::*;

    // Each table row gives the slots to allocate, the fill order (0 in order,
    // 1 reversed, 2 shuffled) and the lanes (01 lane A, 10 lane B, 11 alternating)
    typedef struct packed
    {
        logic [7:0] n;
        logic [1:0] order;
        logic [1:0] lanes;
    } row_t;

    logic      clk0;
    logic      rst_n;
    logic      alloc_en;
    logic      alloc_ok;
    rob_idx_t  alloc_idx;
    logic      rsp_a_en;
    rob_idx_t  rsp_a_idx;
    rob_data_t rsp_a_data;
    logic      rsp_b_en;
    rob_idx_t  rsp_b_idx;
    rob_data_t rsp_b_data;
    logic      out_valid;
    rob_idx_t  out_idx;
    rob_data_t out_data;

    row_t      rows [0:5];
    integer    seed = 32'hdb71_cc61;
    // The scoreboard keeps the data per slot and the slots with data on the way
    // The queues hold slots in allocation order
    rob_data_t exp_data [0:`ROB_ENTRIES-1];
    logic      landed [0:`ROB_ENTRIES-1];
    rob_idx_t  exp_q [$];
    rob_idx_t  pend_q [$];
    rob_idx_t  tail_m;
    rob_idx_t  want;
    int        r;

    rob_top UUT
    (
        .clk0 (clk0), .rst_n (rst_n),
        .alloc_en (alloc_en), .alloc_ok (alloc_ok), .alloc_idx (alloc_idx),
        .rsp_a_en (rsp_a_en), .rsp_a_idx (rsp_a_idx), .rsp_a_data (rsp_a_data),
        .rsp_b_en (rsp_b_en), .rsp_b_idx (rsp_b_idx), .rsp_b_data (rsp_b_data),
        .out_valid (out_valid), .out_idx (out_idx), .out_data (out_data)
    );

    always #4 clk0 = ~clk0;

    task automatic abort_run();
        begin
            $display("FAIL: see errors above");
            $fatal(1);
        end
    endtask

    task automatic check_idx(input string name, input rob_idx_t exp, input rob_idx_t act);
        begin
            if (act !== exp)
            begin
                $display("ERR t=%0t %s expected %0h actual %0h", $time, name, exp, act);
                abort_run();
            end
        end
    endtask

    task automatic check_data(input string name, input rob_data_t exp, input rob_data_t act);
        begin
            if (act !== exp)
            begin
                $display("ERR t=%0t %s expected %08h actual %08h", $time, name, exp, act);
                abort_run();
            end
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        begin
            if (act !== exp)
            begin
                $display("ERR t=%0t %s expected %0b actual %0b", $time, name, exp, act);
                abort_run();
            end
        end
    endtask

    // Takes n slots back to back and checks that each one is the ring tail
    task automatic allocate(input int n);
        int k;
        begin
            for (k = 0; k < n; k++)
            begin
                @(posedge clk0);
                alloc_en <= 1'b1;
                @(negedge clk0);
                check_flag("alloc_ok", 1'b1, alloc_ok);
                check_idx("alloc_idx", tail_m, alloc_idx);
                exp_q.push_back(tail_m);
                pend_q.push_back(tail_m);
                tail_m = tail_m + 1'b1;
            end
            @(posedge clk0);
            alloc_en <= 1'b0;
        end
    endtask

    // Fills the n oldest pending slots, one per cycle, in the chosen order and lanes
    task automatic fill_slots(input int n, input logic [1:0] order, input logic [1:0] lanes);
        rob_idx_t  pick [$];
        rob_idx_t  tmp;
        rob_data_t word;
        logic      use_b;
        int        k;
        int        j;
        begin
            for (k = 0; k < n; k++)
            begin
                if (order == 2'd1)
                    pick.push_front(pend_q.pop_front());
                else
                    pick.push_back(pend_q.pop_front());
            end
            // Fisher-Yates shuffle on the seeded generator
            if (order == 2'd2)
            begin
                for (k = n - 1; k > 0; k--)
                begin
                    j = {$random(seed)} % (k + 1);
                    tmp = pick[k];
                    pick[k] = pick[j];
                    pick[j] = tmp;
                end
            end
            for (k = 0; k < n; k++)
            begin
                use_b = (lanes == 2'b10) || ((lanes == 2'b11) && k[0]);
                word = $random(seed);
                @(posedge clk0);
                exp_data[pick[k]] = word;
                landed[pick[k]] = 1'b1;
                rsp_a_en   <= !use_b;
                rsp_a_idx  <= pick[k];
                rsp_a_data <= word;
                rsp_b_en   <= use_b;
                rsp_b_idx  <= pick[k];
                rsp_b_data <= word;
            end
            @(posedge clk0);
            rsp_a_en <= 1'b0;
            rsp_b_en <= 1'b0;
        end
    endtask

    // Waits until only left entries are still owed on the output
    task automatic wait_drain(input int left);
        int cyc;
        begin
            cyc = 0;
            while ((exp_q.size() > left) && (cyc < 200))
            begin
                @(posedge clk0);
                cyc++;
            end
            if (exp_q.size() > left)
            begin
                $display("Timeout: out_valid never came for %0d entries", exp_q.size() - left);
                abort_run();
            end
        end
    endtask

    // Every output must be the oldest outstanding slot, with its data already written
    always @(negedge clk0)
    begin
        if (rst_n && out_valid)
        begin
            if (exp_q.size() == 0)
            begin
                $display("out_valid at %0t with no entry outstanding", $time);
                abort_run();
            end
            else if (!landed[exp_q[0]])
            begin
                $display("out_valid at %0t before slot %0d was filled", $time, exp_q[0]);
                abort_run();
            end
            else
            begin
                want = exp_q.pop_front();
                check_idx("out_idx", want, out_idx);
                check_data("out_data", exp_data[want], out_data);
                landed[want] = 1'b0;
            end
        end
    end

    initial
    begin
        clk0 = 1'b0;
        rst_n = 1'b0;
        alloc_en = 1'b0;
        rsp_a_en = 1'b0;
        rsp_a_idx = '0;
        rsp_a_data = '0;
        rsp_b_en = 1'b0;
        rsp_b_idx = '0;
        rsp_b_data = '0;
        tail_m = '0;
        for (r = 0; r < `ROB_ENTRIES; r++)
            landed[r] = 1'b0;
        // Rows run past slot 15 so the ring wraps several times
        rows[0] = '{8'd5, 2'd0, 2'b01};
        rows[1] = '{8'd6, 2'd1, 2'b01};
        rows[2] = '{8'd8, 2'd0, 2'b11};
        rows[3] = '{8'd7, 2'd2, 2'b10};
        rows[4] = '{8'd9, 2'd1, 2'b11};
        rows[5] = '{8'd10, 2'd2, 2'b11};
        repeat (3) @(posedge clk0);
        rst_n <= 1'b1;

        // Idle after reset with nothing allocated
        for (r = 0; r < 4; r++)
        begin
            @(negedge clk0);
            check_flag("alloc_ok", 1'b1, alloc_ok);
            check_idx("alloc_idx", '0, alloc_idx);
            check_flag("out_valid", 1'b0, out_valid);
        end

        for (r = 0; r < 6; r++)
        begin
            allocate(rows[r].n);
            fill_slots(rows[r].n, rows[r].order, rows[r].lanes);
            wait_drain(0);
        end

        // Full ring refuses one more allocation until a slot drains
        allocate(`ROB_ENTRIES);
        @(posedge clk0);
        alloc_en <= 1'b1;
        @(posedge clk0);
        alloc_en <= 1'b0;
        @(negedge clk0);
        check_flag("alloc_ok", 1'b0, alloc_ok);
        check_idx("alloc_idx", tail_m, alloc_idx);
        fill_slots(1, 2'd0, 2'b01);
        wait_drain(`ROB_ENTRIES - 1);
        @(negedge clk0);
        check_flag("alloc_ok", 1'b1, alloc_ok);
        fill_slots(`ROB_ENTRIES - 1, 2'd2, 2'b11);
        wait_drain(0);

        $display("PASS: all tests");
        $finish;
    end

endmodule

//--- rob_asserts.sv
/*
 * Fill legality checks for the reorder buffer, bound into every rob_fill_track.
 * Reset masks all checks.
 */
`timescale 1ns/1ps
`include "rob_consts.svh"

module rob_asserts
(
    input logic                    clk0,
    input logic                    rst_n,
    input logic                    rsp_a_en,
    input rob_pkg::rob_idx_t       rsp_a_idx,
    input logic                    rsp_b_en,
    input rob_pkg::rob_idx_t       rsp_b_idx,
    input logic                    pop,
    input rob_pkg::rob_idx_t       head,
    input logic [`ROB_ENTRIES-1:0] filled
);

    // A lane may only land on a slot whose response is still missing
    lane_a_fresh: assert property (@(posedge clk0) disable iff (!rst_n)
        rsp_a_en |-> !filled[rsp_a_idx])
        else $error("lane A wrote slot %0d, which was already filled", rsp_a_idx);

    lane_b_fresh: assert property (@(posedge clk0) disable iff (!rst_n)
        rsp_b_en |-> !filled[rsp_b_idx])
        else $error("lane B wrote slot %0d, which was already filled", rsp_b_idx);

    // Both lanes on one slot in a cycle would race in the RAM
    lanes_apart: assert property (@(posedge clk0) disable iff (!rst_n)
        (rsp_a_en && rsp_b_en) |-> (rsp_a_idx != rsp_b_idx))
        else $error("lanes A and B named slot %0d in the same cycle", rsp_a_idx);

    // A pop releases the head slot, so its bit is clear on the next cycle
    pop_clears: assert property (@(posedge clk0) disable iff (!rst_n)
        pop |=> !filled[$past(head)])
        else $error("a popped slot was still marked filled on the next cycle");

endmodule

bind rob_fill_track rob_asserts u_asserts
(
    .clk0      (clk0),
    .rst_n     (rst_n),
    .rsp_a_en  (rsp_a_en),
    .rsp_a_idx (rsp_a_idx),
    .rsp_b_en  (rsp_b_en),
    .rsp_b_idx (rsp_b_idx),
    .pop       (pop),
    .head      (head),
    .filled    (filled)
);

//--- rob_top.sv
/*
 * Reorder buffer top level. Responses arrive on lanes A and B in any order
 * and leave in allocation order. The output has no back-pressure.
 */
`timescale 1ns/1ps
`include "rob_consts.svh"

module rob_top
(
    input  logic               clk0,
    input  logic               rst_n,

    // Allocation
    input  logic               alloc_en,
    output logic               alloc_ok,
    output rob_pkg::rob_idx_t  alloc_idx,

    // Response lane A, written through RAM port 0
    input  logic               rsp_a_en,
    input  rob_pkg::rob_idx_t  rsp_a_idx,
    input  rob_pkg::rob_data_t rsp_a_data,

    // Response lane B, written through RAM port 1
    input  logic               rsp_b_en,
    input  rob_pkg::rob_idx_t  rsp_b_idx,
    input  rob_pkg::rob_data_t rsp_b_data,

    // In-order output
    output logic               out_valid,
    output rob_pkg::rob_idx_t  out_idx,
    output rob_pkg::rob_data_t out_data
);

    import rob_pkg::*;

    // Drain handshake with the allocator and the fill tracker
    logic     pop;
    logic     head_filled;
    rob_idx_t head;

    // RAM port 1, shared by lane B and the drain
    rob_idx_t  addr1;
    rob_data_t rdata1;

    rob_slot_alloc u_slot_alloc
    (
        .clk0      (clk0),
        .rst_n     (rst_n),
        .alloc_en  (alloc_en),
        .pop       (pop),
        .alloc_ok  (alloc_ok),
        .alloc_idx (alloc_idx)
    );

    rob_fill_track u_fill_track
    (
        .clk0        (clk0),
        .rst_n       (rst_n),
        .rsp_a_en    (rsp_a_en),
        .rsp_a_idx   (rsp_a_idx),
        .rsp_b_en    (rsp_b_en),
        .rsp_b_idx   (rsp_b_idx),
        .pop         (pop),
        .head        (head),
        .head_filled (head_filled)
    );

    rob_drain u_drain
    (
        .clk0        (clk0),
        .rst_n       (rst_n),
        .head_filled (head_filled),
        .rsp_b_en    (rsp_b_en),
        .rsp_b_idx   (rsp_b_idx),
        .rdata1      (rdata1),
        .head        (head),
        .pop         (pop),
        .addr1       (addr1),
        .out_valid   (out_valid),
        .out_idx     (out_idx),
        .out_data    (out_data)
    );

    // Both RAM ports run on clk0
    // Port 0 read data is not needed, since lane A only writes
    rob_dualport_ram
    #(
        .N_ENTRIES   (`ROB_ENTRIES),
        .N_DATA_BITS (`ROB_DATA_BITS)
    )
    u_ram
    (
        .clk0   (clk0),
        .addr0  (rsp_a_idx),
        .wen0   (rsp_a_en),
        .wdata0 (rsp_a_data),
        .rdata0 (),
        .clk1   (clk0),
        .addr1  (addr1),
        .wen1   (rsp_b_en),
        .wdata1 (rsp_b_data),
        .rdata1 (rdata1)
    );

endmodule

//--- rob_drain.sv
/*
 * Releases entries in ring order, one per cycle at most. Lane B owns RAM
 * port 1 whenever it writes, which stalls the drain for that cycle.
 */
`timescale 1ns/1ps

module rob_drain
(
    input  logic               clk0,
    input  logic               rst_n,
    input  logic               head_filled,
    input  logic               rsp_b_en,
    input  rob_pkg::rob_idx_t  rsp_b_idx,
    input  rob_pkg::rob_data_t rdata1,
    output rob_pkg::rob_idx_t  head,
    output logic               pop,
    output rob_pkg::rob_idx_t  addr1,
    output logic               out_valid,
    output rob_pkg::rob_idx_t  out_idx,
    output rob_pkg::rob_data_t out_data
);

    import rob_pkg::*;

    // Oldest slot still waiting to leave
    rob_idx_t head_q;

    // Pop only a filled head, and only while lane B leaves port 1 alone
    assign pop = head_filled & ~rsp_b_en;

    // Lane B writes take the port, otherwise the head is read
    assign addr1 = rsp_b_en ? rsp_b_idx : head_q;

    assign head = head_q;

    // The head steps forward on each pop and wraps with the ring
    always_ff @(posedge clk0 or negedge rst_n)
    begin
        if (!rst_n)
        begin
            head_q <= '0;
        end
        else if (pop)
        begin
            head_q <= head_q + 1'b1;
        end
    end

    // out_valid trails pop by the one cycle of RAM read latency
    always_ff @(posedge clk0 or negedge rst_n)
    begin
        if (!rst_n)
            out_valid <= 1'b0;
        else
            out_valid <= pop;
    end

    // Index of the popped slot, aligned with its data on rdata1
    always_ff @(posedge clk0)
    begin
        if (pop)
        begin
            out_idx <= head_q;
        end
    end

    // The RAM output register already holds the word, so it goes out as is
    // It is only meaningful while out_valid is high
    assign out_data = rdata1;

endmodule

//--- rob_fill_track.sv
/*
 * One filled bit per slot. The two lanes never name one slot in a cycle,
 * and a lane only fills an allocated slot whose bit is clear.
 */
`timescale 1ns/1ps
`include "rob_consts.svh"

module rob_fill_track
(
    input  logic              clk0,
    input  logic              rst_n,
    input  logic              rsp_a_en,
    input  rob_pkg::rob_idx_t rsp_a_idx,
    input  logic              rsp_b_en,
    input  rob_pkg::rob_idx_t rsp_b_idx,
    input  logic              pop,
    input  rob_pkg::rob_idx_t head,
    output logic              head_filled
);

    import rob_pkg::*;

    // A set bit marks a slot whose response has landed in the RAM
    logic [`ROB_ENTRIES-1:0] filled;
    // Bits that the lanes set and the drain clears this cycle
    logic [`ROB_ENTRIES-1:0] set_mask;
    logic [`ROB_ENTRIES-1:0] clr_mask;

    always_comb
    begin
        set_mask = '0;
        clr_mask = '0;
        if (rsp_a_en)
            set_mask[rsp_a_idx] = 1'b1;
        if (rsp_b_en)
            set_mask[rsp_b_idx] = 1'b1;
        // The drain only pops a filled head, so set and clear never meet
        if (pop)
            clr_mask[head] = 1'b1;
    end

    always_ff @(posedge clk0 or negedge rst_n)
    begin
        if (!rst_n)
            filled <= '0;
        else
            filled <= (filled & ~clr_mask) | set_mask;
    end

    // A fill shows here the cycle after its strobe
    assign head_filled = filled[head];

endmodule

//--- rob_slot_alloc.sv
/*
 * Ring tail and occupancy of the reorder buffer. An alloc_en while alloc_ok
 * is low is dropped. pop must only come for an occupied slot.
 */
`timescale 1ns/1ps
`include "rob_consts.svh"

module rob_slot_alloc
(
    input  logic              clk0,
    input  logic              rst_n,
    input  logic              alloc_en,
    input  logic              pop,
    output logic              alloc_ok,
    output rob_pkg::rob_idx_t alloc_idx
);

    import rob_pkg::*;

    // Next slot to hand out
    rob_idx_t   tail;
    // Slots taken and not yet drained
    rob_count_t count;
    // Allocation request that the buffer can honour this cycle
    logic       alloc_acc;

    // Room is left while fewer than ROB_ENTRIES slots are taken
    assign alloc_ok  = (count < rob_count_t'(`ROB_ENTRIES));
    assign alloc_acc = alloc_en & alloc_ok;

    // The requester always sees the tail, and takes it with alloc_en
    assign alloc_idx = tail;

    // Tail moves one slot per accepted allocation
    // The depth is a power of two, so the index wraps by overflow
    always_ff @(posedge clk0 or negedge rst_n)
    begin
        if (!rst_n)
        begin
            tail <= '0;
        end
        else if (alloc_acc)
        begin
            tail <= tail + 1'b1;
        end
    end

    // Occupancy goes up on allocation and down on pop
    // Both in one cycle leave it unchanged
    always_ff @(posedge clk0 or negedge rst_n)
    begin
        if (!rst_n)
        begin
            count <= '0;
        end
        else
        begin
            case ({alloc_acc, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- rob_dualport_ram.sv
/*
 * Two-port block RAM without reset. A writing port returns its own new word.
 * A read of a word that the other port writes in the same edge returns the old word.
 */
`timescale 1ns/1ps

module rob_dualport_ram
#(
    parameter int N_ENTRIES   = 16,
    parameter int N_DATA_BITS = 32
)
(
    input  logic                   clk0,
    input  rob_pkg::rob_idx_t      addr0,
    input  logic                   wen0,
    input  logic [N_DATA_BITS-1:0] wdata0,
    output logic [N_DATA_BITS-1:0] rdata0,

    input  logic                   clk1,
    input  rob_pkg::rob_idx_t      addr1,
    input  logic                   wen1,
    input  logic [N_DATA_BITS-1:0] wdata1,
    output logic [N_DATA_BITS-1:0] rdata1
);

    // Storage array, one word per slot
    logic [N_DATA_BITS-1:0] mem [0:N_ENTRIES-1];

    // Port 0 writes on clk0 and bypasses its write data to rdata0
    always_ff @(posedge clk0)
    begin
        if (wen0)
        begin
            mem[addr0] <= wdata0;
            rdata0     <= wdata0;
        end
        else
        begin
            // Registered read, so the word shows one cycle after the address
            rdata0 <= mem[addr0];
        end
    end

    // Port 1 mirrors port 0 on its own clock
    always_ff @(posedge clk1)
    begin
        if (wen1)
        begin
            mem[addr1] <= wdata1;
            rdata1     <= wdata1;
        end
        else
        begin
            rdata1 <= mem[addr1];
        end
    end

endmodule

//--- rob_pkg.sv
/*
 * Shared types of the reorder buffer. Widths follow rob_consts.svh.
 */
`include "rob_consts.svh"

package rob_pkg;

    // Slot index, wide enough to name every entry of the ring
    typedef logic [$clog2(`ROB_ENTRIES)-1:0] rob_idx_t;

    // Occupancy count, one bit wider than the index
    // A full ring of ROB_ENTRIES slots needs the extra bit
    typedef logic [$clog2(`ROB_ENTRIES):0] rob_count_t;

    // One response payload word
    typedef logic [`ROB_DATA_BITS-1:0] rob_data_t;

endpackage

//--- rob_consts.svh
/*
 * Sizing constants for the reorder buffer. ROB_ENTRIES must be a power of two
 * so that the ring pointers wrap by plain overflow.
 */
`ifndef ROB_CONSTS_SVH
`define ROB_CONSTS_SVH

// Number of slots in the ring, and so the RAM depth
`define ROB_ENTRIES 16

// Width of one response data word
`define ROB_DATA_BITS 32

`endif
